/* verilog/box_pkg.sv */
`default_nettype none

package box_pkg;

  // wishbone port geometry.
  localparam int ADR_W = 12;
  localparam int DAT_W = 32;
  localparam int SUM_W = 16;

  // address bits 11:10 pick the region.
  localparam logic [1:0] REGION_CTRL = 2'd0;
  localparam logic [1:0] REGION_PIX  = 2'd1;
  localparam logic [1:0] REGION_RES  = 2'd2;

  // strobes from the sweep FSM.
  typedef struct packed {
    logic start_en;
    logic ld_en;
    logic count_en;
    logic sum_en;
    logic cum_en;
    logic progress_done;
  } sweep_cmd_t;

  // one finished window sum, tagged with its place in the result array.
  typedef struct packed {
    logic             valid;
    logic [3:0]       row;
    logic [5:0]       col;
    logic [SUM_W-1:0] sum;
  } sum_beat_t;

  // register word as written by the host.
  typedef struct packed {
    logic [26:0] reserved;
    logic [3:0]  rows;
    logic        start;
  } csr_cmd_t;

  // register word as read back by the host.
  typedef struct packed {
    logic [25:0] reserved;
    logic [3:0]  rows_done;
    logic        done;
    logic        busy;
  } csr_stat_t;

  typedef union packed {
    csr_cmd_t  cmd;
    csr_stat_t stat;
  } csr_word_t;

endpackage

`default_nettype wire

/* verilog/row_sweep_ctrl.sv */
`default_nettype none

module row_sweep_ctrl #(
  parameter int COLS = 16,
  parameter int WIN  = 5
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_start,
  input  logic                i_start_gt_1,
  input  logic [5:0]          i_col_count,
  input  logic                i_row_eq_max,
  output box_pkg::sweep_cmd_t o_cmd
);

  import box_pkg::*;

  localparam logic [2:0] S_IDLE      = 3'd0;
  localparam logic [2:0] S_START     = 3'd1;
  localparam logic [2:0] S_START_ROW = 3'd2;
  localparam logic [2:0] S_FILL      = 3'd3;
  localparam logic [2:0] S_EMIT      = 3'd4;
  localparam logic [2:0] S_FINISH    = 3'd5;
  localparam logic [2:0] S_DONE      = 3'd6;

  // column being addressed when the window fill or the row ends.
  localparam logic [5:0] FILL_LAST = 6'(WIN - 2);
  localparam logic [5:0] LAST_COL  = 6'(COLS - 1);

  logic [2:0] state_q;
  logic [2:0] state_nxt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      S_IDLE: begin
        if (i_start) begin
          state_nxt = S_START;
        end
      end
      // zero rows requested skips the sweep entirely.
      S_START: begin
        state_nxt = i_start_gt_1 ? S_START_ROW : S_FINISH;
      end
      // col 0 goes out here, so a two-wide window needs no fill.
      S_START_ROW: begin
        state_nxt = (WIN > 2) ? S_FILL : S_EMIT;
      end
      S_FILL: begin
        if (i_col_count == FILL_LAST) begin
          state_nxt = S_EMIT;
        end
      end
      S_EMIT: begin
        if (i_col_count == LAST_COL) begin
          state_nxt = i_row_eq_max ? S_FINISH : S_START_ROW;
        end
      end
      S_FINISH: begin
        state_nxt = S_DONE;
      end
      S_DONE: begin
        state_nxt = S_IDLE;
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  always_comb begin
    o_cmd = '0;
    case (state_q)
      S_START: begin
        o_cmd.start_en = 1'b1;
      end
      S_START_ROW: begin
        o_cmd.ld_en    = 1'b1;
        o_cmd.count_en = 1'b1;
        o_cmd.sum_en   = 1'b1;
      end
      S_FILL: begin
        o_cmd.count_en = 1'b1;
        o_cmd.sum_en   = 1'b1;
      end
      S_EMIT: begin
        o_cmd.count_en = 1'b1;
        o_cmd.sum_en   = 1'b1;
        o_cmd.cum_en   = 1'b1;
      end
      S_FINISH: begin
        o_cmd.progress_done = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // a row start never coincides with an emitting column.
  a_ld_cum_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_cmd.ld_en && o_cmd.cum_en));

endmodule

`default_nettype wire

/* verilog/window_sum_path.sv */
`default_nettype none

module window_sum_path #(
  parameter int COLS     = 16,
  parameter int ROWS_MAX = 8,
  parameter int WIN      = 5,
  parameter int PIX_W    = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  box_pkg::sweep_cmd_t i_cmd,
  input  logic [3:0]          i_rows,
  input  logic [PIX_W-1:0]    i_pix_data,
  output logic [9:0]          o_pix_addr,
  output logic [5:0]          o_col_count,
  output logic                o_start_gt_1,
  output logic                o_row_eq_max,
  output box_pkg::sum_beat_t  o_beat
);

  import box_pkg::*;

  localparam logic [5:0] LAST_COL = 6'(COLS - 1);
  localparam logic [5:0] WIN_M1   = 6'(WIN - 1);

  logic [5:0]       col_q;
  logic [3:0]       row_q;
  logic             ld_q;
  logic             acc_q;
  logic             cum_q;
  logic [5:0]       col_t;
  logic [3:0]       row_t;
  logic [PIX_W-1:0] win_q [WIN];
  logic [SUM_W-1:0] run_sum_q;
  logic [SUM_W-1:0] sum_nxt;
  logic [PIX_W-1:0] leaving;

  // sweep position.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (i_cmd.start_en) begin
      col_q <= '0;
      row_q <= '0;
    end else if (i_cmd.count_en) begin
      if (col_q == LAST_COL) begin
        col_q <= '0;
        row_q <= row_q + 4'd1;
      end else begin
        col_q <= col_q + 6'd1;
      end
    end
  end

  assign o_pix_addr   = 10'(row_q * COLS + col_q);
  assign o_col_count  = col_q;
  assign o_start_gt_1 = (i_rows != 4'd0);
  assign o_row_eq_max = (row_q == i_rows - 4'd1);

  // strobes follow the pixel, which is one cycle behind its address.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ld_q  <= 1'b0;
      acc_q <= 1'b0;
      cum_q <= 1'b0;
    end else begin
      ld_q  <= i_cmd.ld_en;
      acc_q <= i_cmd.sum_en;
      cum_q <= i_cmd.cum_en;
    end
  end

  always_ff @(posedge clk) begin
    col_t <= col_q;
    row_t <= row_q;
  end

  // the window starts empty, so the first emit drops a zero.
  always_comb begin
    leaving = cum_q ? win_q[WIN-1] : '0;
    if (ld_q) begin
      sum_nxt = SUM_W'(i_pix_data);
    end else begin
      sum_nxt = run_sum_q + SUM_W'(i_pix_data) - SUM_W'(leaving);
    end
  end

  always_ff @(posedge clk) begin
    if (acc_q) begin
      run_sum_q <= sum_nxt;
      win_q[0]  <= i_pix_data;
      for (int i = 1; i < WIN; i++) begin
        win_q[i] <= ld_q ? '0 : win_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_beat.valid <= 1'b0;
    end else begin
      o_beat.valid <= cum_q;
    end
  end

  always_ff @(posedge clk) begin
    o_beat.row <= row_t;
    o_beat.col <= col_t - WIN_M1;
    o_beat.sum <= sum_nxt;
  end

  // every stored beat lands inside the result array.
  a_beat_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    o_beat.valid |-> (o_beat.col <= 6'(COLS - WIN)) && (o_beat.row < 4'(ROWS_MAX)));

endmodule

`default_nettype wire

/* verilog/wb_frame_port.sv */
`default_nettype none

module wb_frame_port #(
  parameter int COLS     = 16,
  parameter int ROWS_MAX = 8,
  parameter int WIN      = 5,
  parameter int PIX_W    = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_wb_cyc,
  input  logic                      i_wb_stb,
  input  logic                      i_wb_we,
  input  logic [box_pkg::ADR_W-1:0] i_wb_adr,
  input  logic [box_pkg::DAT_W-1:0] i_wb_dat,
  input  logic [9:0]                i_pix_addr,
  input  box_pkg::sum_beat_t        i_beat,
  input  box_pkg::sweep_cmd_t       i_cmd,
  output logic [box_pkg::DAT_W-1:0] o_wb_dat,
  output logic                      o_wb_ack,
  output logic                      o_start,
  output logic [3:0]                o_rows,
  output logic [PIX_W-1:0]          o_pix_data
);

  import box_pkg::*;

  localparam int RES_COLS  = COLS - WIN + 1;
  localparam int PIX_DEPTH = COLS * ROWS_MAX;
  localparam int RES_DEPTH = RES_COLS * ROWS_MAX;
  localparam int PIX_AW    = $clog2(PIX_DEPTH);
  localparam int RES_AW    = $clog2(RES_DEPTH);

  logic [PIX_W-1:0] pix_mem [PIX_DEPTH];
  logic [SUM_W-1:0] res_mem [RES_DEPTH];

  logic [1:0]  region;
  logic [9:0]  word;
  logic        wb_req;
  logic        start_req;
  logic [3:0]  rows_req;
  csr_word_t   wr_word;
  csr_word_t   stat_word;
  logic        busy_q;
  logic        done_q;
  logic [3:0]  rows_done_q;
  logic        fin_q;
  logic [RES_AW-1:0] res_wr_idx;

  assign region = i_wb_adr[11:10];
  assign word   = i_wb_adr[9:0];
  // new cycles are only taken while no ack is out.
  assign wb_req  = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign wr_word = i_wb_dat;

  assign start_req = wb_req && i_wb_we && (region == REGION_CTRL) && (word == 10'd0) &&
                     wr_word.cmd.start && !busy_q;
  assign rows_req  = (wr_word.cmd.rows > 4'(ROWS_MAX)) ? 4'(ROWS_MAX) : wr_word.cmd.rows;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_wb_ack <= 1'b0;
      o_start  <= 1'b0;
      fin_q    <= 1'b0;
    end else begin
      o_wb_ack <= wb_req;
      o_start  <= start_req;
      fin_q    <= i_cmd.progress_done;
    end
  end

  always_ff @(posedge clk) begin
    if (start_req) begin
      o_rows <= rows_req;
    end
  end

  // busy drops one cycle after progress_done, once the last beat is stored.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      rows_done_q <= '0;
    end else if (start_req) begin
      busy_q      <= 1'b1;
      done_q      <= 1'b0;
      rows_done_q <= '0;
    end else begin
      if (fin_q) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      if (i_beat.valid && (i_beat.col == 6'(RES_COLS - 1))) begin
        rows_done_q <= rows_done_q + 4'd1;
      end
    end
  end

  // pixel memory: host writes, datapath reads.
  always_ff @(posedge clk) begin
    if (wb_req && i_wb_we && (region == REGION_PIX) && !busy_q && (word < PIX_DEPTH)) begin
      pix_mem[word[PIX_AW-1:0]] <= i_wb_dat[PIX_W-1:0];
    end
    o_pix_data <= pix_mem[i_pix_addr[PIX_AW-1:0]];
  end

  assign res_wr_idx = RES_AW'(i_beat.row * RES_COLS + i_beat.col);

  always_ff @(posedge clk) begin
    if (i_beat.valid) begin
      res_mem[res_wr_idx] <= i_beat.sum;
    end
  end

  always_comb begin
    stat_word                = '0;
    stat_word.stat.busy      = busy_q;
    stat_word.stat.done      = done_q;
    stat_word.stat.rows_done = rows_done_q;
  end

  always_ff @(posedge clk) begin
    if (wb_req && !i_wb_we) begin
      o_wb_dat <= '0;
      case (region)
        REGION_CTRL: begin
          if (word == 10'd0) begin
            o_wb_dat <= stat_word;
          end
        end
        REGION_PIX: begin
          if (word < PIX_DEPTH) begin
            o_wb_dat <= DAT_W'(pix_mem[word[PIX_AW-1:0]]);
          end
        end
        REGION_RES: begin
          if (word < RES_DEPTH) begin
            o_wb_dat <= DAT_W'(res_mem[word[RES_AW-1:0]]);
          end
        end
        default: begin
        end
      endcase
    end
  end

  // classic cycles: one ack per request, then a gap.
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    o_wb_ack |=> !o_wb_ack);

endmodule

`default_nettype wire

/* verilog/box_row_top.sv */
`default_nettype none

module box_row_top #(
  parameter int COLS     = 16,
  parameter int ROWS_MAX = 8,
  parameter int WIN      = 5,
  parameter int PIX_W    = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_wb_cyc,
  input  logic                      i_wb_stb,
  input  logic                      i_wb_we,
  input  logic [box_pkg::ADR_W-1:0] i_wb_adr,
  input  logic [box_pkg::DAT_W-1:0] i_wb_dat,
  output logic [box_pkg::DAT_W-1:0] o_wb_dat,
  output logic                      o_wb_ack
);

  import box_pkg::*;

  logic             start;
  logic [3:0]       rows;
  sweep_cmd_t       cmd;
  logic [9:0]       pix_addr;
  logic [PIX_W-1:0] pix_data;
  sum_beat_t        beat;
  logic [5:0]       col_count;
  logic             start_gt_1;
  logic             row_eq_max;

  row_sweep_ctrl #(
    .COLS (COLS),
    .WIN  (WIN)
  ) i_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_start      (start),
    .i_start_gt_1 (start_gt_1),
    .i_col_count  (col_count),
    .i_row_eq_max (row_eq_max),
    .o_cmd        (cmd)
  );

  window_sum_path #(
    .COLS     (COLS),
    .ROWS_MAX (ROWS_MAX),
    .WIN      (WIN),
    .PIX_W    (PIX_W)
  ) i_path (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_cmd        (cmd),
    .i_rows       (rows),
    .i_pix_data   (pix_data),
    .o_pix_addr   (pix_addr),
    .o_col_count  (col_count),
    .o_start_gt_1 (start_gt_1),
    .o_row_eq_max (row_eq_max),
    .o_beat       (beat)
  );

  wb_frame_port #(
    .COLS     (COLS),
    .ROWS_MAX (ROWS_MAX),
    .WIN      (WIN),
    .PIX_W    (PIX_W)
  ) i_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .i_wb_we    (i_wb_we),
    .i_wb_adr   (i_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .i_pix_addr (pix_addr),
    .i_beat     (beat),
    .i_cmd      (cmd),
    .o_wb_dat   (o_wb_dat),
    .o_wb_ack   (o_wb_ack),
    .o_start    (start),
    .o_rows     (rows),
    .o_pix_data (pix_data)
  );

endmodule

`default_nettype wire

/* bench/box_row_tb.sv */
`default_nettype none

module box_row_tb;

  import box_pkg::*;

  localparam int COLS       = 16;
  localparam int ROWS_MAX   = 8;
  localparam int WIN        = 5;
  localparam int PIX_W      = 8;
  localparam int RES_COLS   = COLS - WIN + 1;
  localparam int NUM_TESTS  = 5;
  localparam int WATCHDOG   = NUM_TESTS * ROWS_MAX * COLS * 20 + 5000;
  localparam int ACK_LIMIT  = 50;
  localparam int POLL_LIMIT = 500;
  localparam logic [31:0]      SEED    = 32'h20b75521;
  localparam logic [ADR_W-1:0] CSR_ADR = '0;

  logic             clk;
  logic             rst_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [ADR_W-1:0] wb_adr;
  logic [DAT_W-1:0] wb_wdat;
  logic [DAT_W-1:0] wb_rdat;
  logic             wb_ack;

  int               errors;
  int               checks;
  int               ack_total = 0;
  string            test_name;
  logic [31:0]      rng_state;
  logic [PIX_W-1:0] pix_ref [ROWS_MAX*COLS];
  int               old_exp [ROWS_MAX*RES_COLS];

  box_row_top #(
    .COLS     (COLS),
    .ROWS_MAX (ROWS_MAX),
    .WIN      (WIN),
    .PIX_W    (PIX_W)
  ) i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_we  (wb_we),
    .i_wb_adr (wb_adr),
    .i_wb_dat (wb_wdat),
    .o_wb_dat (wb_rdat),
    .o_wb_ack (wb_ack)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ack is sampled mid-cycle, away from the edge.
  always @(negedge clk) begin
    if (wb_ack) begin
      ack_total++;
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [ADR_W-1:0] pix_adr(input int idx);
    return {REGION_PIX, 10'(idx)};
  endfunction

  function automatic logic [ADR_W-1:0] res_adr(input int idx);
    return {REGION_RES, 10'(idx)};
  endfunction

  // reference sum of WIN neighbours along one row.
  function automatic int expected_sum(input int row, input int col);
    int acc;
    acc = 0;
    for (int k = 0; k < WIN; k++) begin
      acc += int'(pix_ref[row*COLS + col + k]);
    end
    return acc;
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      $display("error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // one classic cycle, held until ack.
  task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                           input logic [DAT_W-1:0] wdat, output logic [DAT_W-1:0] rdat);
    int waited;
    logic acked;
    waited  = 0;
    acked   = 1'b0;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = wdat;
    while (!acked && waited < ACK_LIMIT) begin
      @(posedge clk);
      #10;
      acked = wb_ack;
      waited++;
    end
    rdat   = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    assert (acked) else begin
      $display("%s: no ack within %0d cycles at address 0x%03h", test_name, ACK_LIMIT, adr);
      errors++;
    end
  endtask

  task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat);
    logic [DAT_W-1:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] dat);
    bus_cycle(1'b0, adr, '0, dat);
  endtask

  task automatic fill_random(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      rng_state  = xorshift32(rng_state);
      pix_ref[i] = rng_state[PIX_W-1:0];
    end
  endtask

  task automatic load_pixels(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      wb_write(pix_adr(i), DAT_W'(pix_ref[i]));
    end
  endtask

  task automatic start_frame(input int rows);
    csr_word_t w;
    w           = '0;
    w.cmd.start = 1'b1;
    w.cmd.rows  = 4'(rows);
    wb_write(CSR_ADR, w);
  endtask

  task automatic wait_idle(output csr_word_t st);
    logic [DAT_W-1:0] rdat;
    int polls;
    polls = 0;
    wb_read(CSR_ADR, rdat);
    st = rdat;
    while (st.stat.busy && polls < POLL_LIMIT) begin
      wb_read(CSR_ADR, rdat);
      st = rdat;
      polls++;
    end
    assert (!st.stat.busy) else begin
      $display("%s: frame still busy after %0d status polls", test_name, POLL_LIMIT);
      errors++;
    end
  endtask

  task automatic check_status(input csr_word_t st, input int busy, input int done,
                              input int rows_done);
    check_value("busy", busy, int'(st.stat.busy));
    check_value("done", done, int'(st.stat.done));
    check_value("rows_done", rows_done, int'(st.stat.rows_done));
  endtask

  task automatic check_results(input int rows);
    logic [DAT_W-1:0] rdat;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < RES_COLS; c++) begin
        wb_read(res_adr(r*RES_COLS + c), rdat);
        check_value($sformatf("sum row %0d col %0d", r, c), expected_sum(r, c), int'(rdat));
      end
    end
  endtask

  task automatic check_kept_rows(input int first_row);
    logic [DAT_W-1:0] rdat;
    for (int r = first_row; r < ROWS_MAX; r++) begin
      for (int c = 0; c < RES_COLS; c++) begin
        wb_read(res_adr(r*RES_COLS + c), rdat);
        check_value($sformatf("kept row %0d col %0d", r, c),
                    old_exp[r*RES_COLS + c], int'(rdat));
      end
    end
  endtask

  task automatic test_reset();
    logic [DAT_W-1:0] rdat;
    csr_word_t st;
    int acks_before;
    test_name   = "test_reset";
    acks_before = ack_total;
    wb_read(CSR_ADR, rdat);
    st = rdat;
    check_status(st, 0, 0, 0);
    repeat (4) @(posedge clk);
    #10;
    check_value("ack count", 1, ack_total - acks_before);
  endtask

  task automatic test_ramp_frame();
    logic [DAT_W-1:0] rdat;
    csr_word_t st;
    test_name = "test_ramp_frame";
    for (int r = 0; r < ROWS_MAX; r++) begin
      for (int c = 0; c < COLS; c++) begin
        pix_ref[r*COLS + c] = PIX_W'(r + c);
      end
    end
    load_pixels(0, ROWS_MAX*COLS);
    start_frame(3);
    wait_idle(st);
    check_status(st, 0, 1, 3);
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < RES_COLS; c++) begin
        wb_read(res_adr(r*RES_COLS + c), rdat);
        check_value($sformatf("ramp row %0d col %0d", r, c),
                    WIN*(r + c) + WIN*(WIN - 1)/2, int'(rdat));
      end
    end
  endtask

  task automatic test_random_frame();
    csr_word_t st;
    test_name = "test_random_frame";
    fill_random(0, ROWS_MAX*COLS);
    // saturated stretches push the sum to its largest value.
    for (int c = 3; c <= 10; c++) begin
      pix_ref[2*COLS + c] = '1;
    end
    for (int c = 0; c < COLS; c++) begin
      pix_ref[5*COLS + c] = '1;
    end
    load_pixels(0, ROWS_MAX*COLS);
    start_frame(ROWS_MAX);
    wait_idle(st);
    check_status(st, 0, 1, ROWS_MAX);
    check_results(ROWS_MAX);
  endtask

  task automatic test_busy_protect();
    logic [DAT_W-1:0] rdat;
    csr_word_t st;
    test_name = "test_busy_protect";
    fill_random(0, ROWS_MAX*COLS);
    load_pixels(0, ROWS_MAX*COLS);
    start_frame(ROWS_MAX);
    wb_read(CSR_ADR, rdat);
    st = rdat;
    check_value("busy after start", 1, int'(st.stat.busy));
    // these land while the sweep runs and must be dropped.
    for (int i = 0; i < 8; i++) begin
      wb_write(pix_adr(i*9), DAT_W'(~pix_ref[i*9]));
    end
    start_frame(1);
    wait_idle(st);
    check_status(st, 0, 1, ROWS_MAX);
    check_results(ROWS_MAX);
    wb_read(pix_adr(9), rdat);
    check_value("pixel 9 kept", int'(pix_ref[9]), int'(rdat));
  endtask

  task automatic test_zero_and_rerun();
    csr_word_t st;
    test_name = "test_zero_and_rerun";
    for (int r = 0; r < ROWS_MAX; r++) begin
      for (int c = 0; c < RES_COLS; c++) begin
        old_exp[r*RES_COLS + c] = expected_sum(r, c);
      end
    end
    // new pixels in rows 0 and 1 expose any row that gets swept.
    fill_random(0, 2*COLS);
    load_pixels(0, 2*COLS);
    start_frame(0);
    wait_idle(st);
    check_status(st, 0, 1, 0);
    check_kept_rows(0);
    // only row 0 is swept.
    start_frame(1);
    wait_idle(st);
    check_status(st, 0, 1, 1);
    check_results(1);
    check_kept_rows(1);
  endtask

  initial begin
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_wdat   = '0;
    errors    = 0;
    checks    = 0;
    rng_state = SEED;
    test_name = "setup";
    repeat (10) @(posedge clk);
    #10;
    rst_n = 1'b1;

    test_reset();
    test_ramp_frame();
    test_random_frame();
    test_busy_protect();
    test_zero_and_rerun();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
verilog/box_pkg.sv
verilog/row_sweep_ctrl.sv
verilog/window_sum_path.sv
verilog/wb_frame_port.sv
verilog/box_row_top.sv
bench/box_row_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= box_row_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST OK

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  build  compile $(TOP) from $(FILELIST) into $(BUILD_DIR)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result line, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
